/* hw/core_pkg.sv */
`default_nettype none

package core_pkg;

	localparam int XLEN = 32;
	localparam int REG_ADDR_W = 5;
	localparam logic [XLEN-1:0] RESET_PC = '0;

	// the only system encoding the core accepts
	localparam logic [XLEN-1:0] EBREAK_INST = 32'h0010_0073;

	// funct fields of the supported encodings
	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_WORD = 3'b010;
	localparam logic [2:0] F3_BEQ = 3'b000;
	localparam logic [2:0] F3_BNE = 3'b001;
	localparam logic [6:0] F7_ADD = 7'b0000000;
	localparam logic [6:0] F7_SUB = 7'b0100000;

	// major opcode, inst[6:0]
	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_LUI    = 7'b0110111,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_BRANCH = 7'b1100011,
		OPC_JAL    = 7'b1101111,
		OPC_SYSTEM = 7'b1110011
	} opcode_e;

	typedef enum logic [3:0] {
		OP_ADD,
		OP_SUB,
		OP_ADDI,
		OP_LUI,
		OP_LW,
		OP_SW,
		OP_BEQ,
		OP_BNE,
		OP_JAL,
		OP_EBREAK,
		OP_INVALID
	} op_e;

	typedef struct packed {
		op_e op;
		logic [REG_ADDR_W-1:0] rd;
		logic [XLEN-1:0] rs1_val;
		logic [XLEN-1:0] rs2_val;
		logic [XLEN-1:0] imm;
		logic [XLEN-1:0] pc;
	} decode_t;

	typedef struct packed {
		op_e op;
		logic [REG_ADDR_W-1:0] rd;
		// alu value, memory address or link value
		logic [XLEN-1:0] result;
		logic [XLEN-1:0] store_data;
		logic [XLEN-1:0] next_pc;
	} exec_t;

	typedef struct packed {
		logic we;
		logic [REG_ADDR_W-1:0] waddr;
		logic [XLEN-1:0] wdata;
	} wb_t;

endpackage

`default_nettype wire

/* hw/fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
	input  logic                     clk,
	input  logic                     reset_i,
	input  logic [core_pkg::XLEN-1:0] imem_rdata_i,
	input  logic                     done_i,
	input  logic [core_pkg::XLEN-1:0] next_pc_i,
	input  logic                     halt_i,
	input  logic                     invalid_i,
	output logic [core_pkg::XLEN-1:0] imem_addr_o,
	output logic [core_pkg::XLEN-1:0] inst_o,
	output logic                     fetch_valid_o,
	output logic [core_pkg::XLEN-1:0] pc_o,
	output logic                     finish_o,
	output logic                     invalid_o
);
	import core_pkg::*;

	typedef enum logic [1:0] {
		FETCH,
		WAIT,
		STOP
	} state_e;

	state_e state;
	logic [XLEN-1:0] pc_q;

	assign imem_addr_o = pc_q;
	assign pc_o = pc_q;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			state <= FETCH;
			pc_q <= RESET_PC;
			fetch_valid_o <= 1'b0;
			finish_o <= 1'b0;
			invalid_o <= 1'b0;
		end else begin
			fetch_valid_o <= 1'b0;
			case (state)
				FETCH: begin
					fetch_valid_o <= 1'b1;
					state <= WAIT;
				end
				WAIT: begin
					// one instruction in flight, wait for its outcome
					if (halt_i) begin
						finish_o <= 1'b1;
						state <= STOP;
					end else if (invalid_i) begin
						invalid_o <= 1'b1;
						state <= STOP;
					end else if (done_i) begin
						pc_q <= next_pc_i;
						state <= FETCH;
					end
				end
				default: state <= STOP;
			endcase
		end
	end

	// instruction word latched in the fetch cycle
	always_ff @(posedge clk) begin
		if (state == FETCH) begin
			inst_o <= imem_rdata_i;
		end
	end

endmodule

`default_nettype wire

/* hw/decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module decoder (
	input  logic                           clk,
	input  logic                           reset_i,
	input  logic [core_pkg::XLEN-1:0]       inst_i,
	input  logic [core_pkg::XLEN-1:0]       pc_i,
	input  logic                           fetch_valid_i,
	input  logic [core_pkg::XLEN-1:0]       rs1_data_i,
	input  logic [core_pkg::XLEN-1:0]       rs2_data_i,
	output logic [core_pkg::REG_ADDR_W-1:0] rs1_addr_o,
	output logic [core_pkg::REG_ADDR_W-1:0] rs2_addr_o,
	output core_pkg::decode_t              dec_o,
	output logic                           dec_valid_o,
	output logic                           invalid_o
);
	import core_pkg::*;

	opcode_e opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	op_e op;
	logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
	logic [XLEN-1:0] imm;

	assign opcode = opcode_e'(inst_i[6:0]);
	assign funct3 = inst_i[14:12];
	assign funct7 = inst_i[31:25];
	assign rs1_addr_o = inst_i[19:15];
	assign rs2_addr_o = inst_i[24:20];

	assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
	assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
	assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
	assign imm_u = {inst_i[31:12], 12'b0};
	assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

	// anything not matched below stays invalid
	always_comb begin
		op = OP_INVALID;
		case (opcode)
			OPC_OP: begin
				if (funct3 == F3_ADD_SUB && funct7 == F7_ADD)
					op = OP_ADD;
				else if (funct3 == F3_ADD_SUB && funct7 == F7_SUB)
					op = OP_SUB;
			end
			OPC_OP_IMM: if (funct3 == F3_ADD_SUB) op = OP_ADDI;
			OPC_LUI: op = OP_LUI;
			OPC_LOAD: if (funct3 == F3_WORD) op = OP_LW;
			OPC_STORE: if (funct3 == F3_WORD) op = OP_SW;
			OPC_BRANCH: begin
				if (funct3 == F3_BEQ)
					op = OP_BEQ;
				else if (funct3 == F3_BNE)
					op = OP_BNE;
			end
			OPC_JAL: op = OP_JAL;
			OPC_SYSTEM: if (inst_i == EBREAK_INST) op = OP_EBREAK;
			default: op = OP_INVALID;
		endcase
	end

	always_comb begin
		case (op)
			OP_ADDI, OP_LW: imm = imm_i;
			OP_SW: imm = imm_s;
			OP_BEQ, OP_BNE: imm = imm_b;
			OP_LUI: imm = imm_u;
			OP_JAL: imm = imm_j;
			default: imm = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			dec_valid_o <= 1'b0;
			invalid_o <= 1'b0;
		end else begin
			dec_valid_o <= fetch_valid_i && (op != OP_INVALID);
			invalid_o <= fetch_valid_i && (op == OP_INVALID);
		end
	end

	always_ff @(posedge clk) begin
		if (fetch_valid_i) begin
			dec_o <= '{op: op, rd: inst_i[11:7], rs1_val: rs1_data_i,
				rs2_val: rs2_data_i, imm: imm, pc: pc_i};
		end
	end

endmodule

`default_nettype wire

/* hw/register_file.sv */
`timescale 1ns/1ps
`default_nettype none

module register_file (
	input  logic                           clk,
	input  logic                           reset_i,
	input  logic [core_pkg::REG_ADDR_W-1:0] rs1_addr_i,
	input  logic [core_pkg::REG_ADDR_W-1:0] rs2_addr_i,
	input  core_pkg::wb_t                  wb_i,
	output logic [core_pkg::XLEN-1:0]       rs1_data_o,
	output logic [core_pkg::XLEN-1:0]       rs2_data_o
);
	import core_pkg::*;

	logic [XLEN-1:0] regs [2**REG_ADDR_W];

	always_ff @(posedge clk) begin
		if (reset_i) begin
			for (int i = 0; i < 2**REG_ADDR_W; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_i.we && wb_i.waddr != '0) begin
			regs[wb_i.waddr] <= wb_i.wdata;
		end
	end

	// x0 reads as zero
	assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
	assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

`default_nettype wire

/* hw/execute_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
	input  logic              clk,
	input  logic              reset_i,
	input  core_pkg::decode_t dec_i,
	input  logic              dec_valid_i,
	output core_pkg::exec_t   ex_o,
	output logic              ex_valid_o
);
	import core_pkg::*;

	logic [XLEN-1:0] pc_plus4;
	logic [XLEN-1:0] pc_target;
	logic [XLEN-1:0] result;
	logic [XLEN-1:0] next_pc;
	logic taken;

	assign pc_plus4 = dec_i.pc + XLEN'(4);
	assign pc_target = dec_i.pc + dec_i.imm;

	// result defaults to the link value for jal
	always_comb begin
		taken = 1'b0;
		result = pc_plus4;
		case (dec_i.op)
			OP_ADD: result = dec_i.rs1_val + dec_i.rs2_val;
			OP_SUB: result = dec_i.rs1_val - dec_i.rs2_val;
			// address for loads and stores
			OP_ADDI, OP_LW, OP_SW: result = dec_i.rs1_val + dec_i.imm;
			OP_LUI: result = dec_i.imm;
			OP_BEQ: taken = (dec_i.rs1_val == dec_i.rs2_val);
			OP_BNE: taken = (dec_i.rs1_val != dec_i.rs2_val);
			OP_JAL: taken = 1'b1;
			default: taken = 1'b0;
		endcase
	end

	assign next_pc = taken ? pc_target : pc_plus4;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			ex_valid_o <= 1'b0;
		end else begin
			ex_valid_o <= dec_valid_i;
		end
	end

	always_ff @(posedge clk) begin
		if (dec_valid_i) begin
			ex_o <= '{op: dec_i.op, rd: dec_i.rd, result: result,
				store_data: dec_i.rs2_val, next_pc: next_pc};
		end
	end

endmodule

`default_nettype wire

/* hw/lsu_wb.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_wb (
	input  logic                     clk,
	input  logic                     reset_i,
	input  core_pkg::exec_t          ex_i,
	input  logic                     ex_valid_i,
	input  logic [core_pkg::XLEN-1:0] dmem_rdata_i,
	output logic [core_pkg::XLEN-1:0] dmem_addr_o,
	output logic [core_pkg::XLEN-1:0] dmem_wdata_o,
	output logic                     dmem_we_o,
	output core_pkg::wb_t            wb_o,
	output logic                     done_o,
	output logic [core_pkg::XLEN-1:0] next_pc_o,
	output logic                     halt_o
);
	import core_pkg::*;

	logic writes_rd;
	logic is_ebreak;

	always_comb begin
		case (ex_i.op)
			OP_ADD, OP_SUB, OP_ADDI, OP_LUI, OP_LW, OP_JAL: writes_rd = 1'b1;
			default: writes_rd = 1'b0;
		endcase
	end

	assign is_ebreak = (ex_i.op == OP_EBREAK);

	// word access only, address comes from the alu
	assign dmem_addr_o = ex_i.result;
	assign dmem_wdata_o = ex_i.store_data;
	assign dmem_we_o = ex_valid_i && (ex_i.op == OP_SW);

	// register file writes on the edge closing this cycle
	assign wb_o.we = ex_valid_i && writes_rd;
	assign wb_o.waddr = ex_i.rd;
	assign wb_o.wdata = (ex_i.op == OP_LW) ? dmem_rdata_i : ex_i.result;

	assign done_o = ex_valid_i && !is_ebreak;
	assign next_pc_o = ex_i.next_pc;

	// ebreak holds the core until reset
	always_ff @(posedge clk) begin
		if (reset_i) begin
			halt_o <= 1'b0;
		end else if (ex_valid_i && is_ebreak) begin
			halt_o <= 1'b1;
		end
	end

endmodule

`default_nettype wire

/* hw/core_top.sv */
`timescale 1ns/1ps
`default_nettype none

module core_top (
	input  logic                     clk,
	input  logic                     reset_i,
	input  logic [core_pkg::XLEN-1:0] imem_rdata_i,
	input  logic [core_pkg::XLEN-1:0] dmem_rdata_i,
	output logic [core_pkg::XLEN-1:0] imem_addr_o,
	output logic [core_pkg::XLEN-1:0] dmem_addr_o,
	output logic [core_pkg::XLEN-1:0] dmem_wdata_o,
	output logic                     dmem_we_o,
	output logic [core_pkg::XLEN-1:0] pc_o,
	output logic                     finish_o,
	output logic                     invalid_o
);
	import core_pkg::*;

	logic [XLEN-1:0] inst;
	logic fetch_valid;
	logic [REG_ADDR_W-1:0] rs1_addr, rs2_addr;
	logic [XLEN-1:0] rs1_data, rs2_data;
	decode_t dec;
	logic dec_valid;
	logic dec_invalid;
	exec_t ex;
	logic ex_valid;
	wb_t wb;
	logic done;
	logic halt;
	logic [XLEN-1:0] next_pc;

	fetch_unit u_fetch (
		.clk           (clk),
		.reset_i       (reset_i),
		.imem_rdata_i  (imem_rdata_i),
		.done_i        (done),
		.next_pc_i     (next_pc),
		.halt_i        (halt),
		.invalid_i     (dec_invalid),
		.imem_addr_o   (imem_addr_o),
		.inst_o        (inst),
		.fetch_valid_o (fetch_valid),
		.pc_o          (pc_o),
		.finish_o      (finish_o),
		.invalid_o     (invalid_o)
	);

	decoder u_decoder (
		.clk           (clk),
		.reset_i       (reset_i),
		.inst_i        (inst),
		.pc_i          (pc_o),
		.fetch_valid_i (fetch_valid),
		.rs1_data_i    (rs1_data),
		.rs2_data_i    (rs2_data),
		.rs1_addr_o    (rs1_addr),
		.rs2_addr_o    (rs2_addr),
		.dec_o         (dec),
		.dec_valid_o   (dec_valid),
		.invalid_o     (dec_invalid)
	);

	register_file u_regfile (
		.clk        (clk),
		.reset_i    (reset_i),
		.rs1_addr_i (rs1_addr),
		.rs2_addr_i (rs2_addr),
		.wb_i       (wb),
		.rs1_data_o (rs1_data),
		.rs2_data_o (rs2_data)
	);

	execute_unit u_execute (
		.clk         (clk),
		.reset_i     (reset_i),
		.dec_i       (dec),
		.dec_valid_i (dec_valid),
		.ex_o        (ex),
		.ex_valid_o  (ex_valid)
	);

	lsu_wb u_lsu_wb (
		.clk          (clk),
		.reset_i      (reset_i),
		.ex_i         (ex),
		.ex_valid_i   (ex_valid),
		.dmem_rdata_i (dmem_rdata_i),
		.dmem_addr_o  (dmem_addr_o),
		.dmem_wdata_o (dmem_wdata_o),
		.dmem_we_o    (dmem_we_o),
		.wb_o         (wb),
		.done_o       (done),
		.next_pc_o    (next_pc),
		.halt_o       (halt)
	);

endmodule

`default_nettype wire

/* bench/core_props.sv */
`timescale 1ns/1ps
`default_nettype none

module core_props (
	input wire logic        clk,
	input wire logic        reset_i,
	input wire logic [31:0] pc_o,
	input wire logic        dmem_we_o,
	input wire logic        finish_o,
	input wire logic        invalid_o
);

	pc_aligned: assert property (@(posedge clk) pc_o[1:0] == 2'b00)
	else $error("pc_o is not word aligned");

	// a store strobe lasts a single cycle
	we_single: assert property (@(posedge clk) disable iff (reset_i)
		dmem_we_o |=> !dmem_we_o)
	else $error("dmem_we_o high for two cycles");

	finish_sticky: assert property (@(posedge clk)
		(finish_o && !reset_i) |=> (finish_o || reset_i))
	else $error("finish_o fell without reset");

	invalid_sticky: assert property (@(posedge clk)
		(invalid_o && !reset_i) |=> (invalid_o || reset_i))
	else $error("invalid_o fell without reset");

	// a halted core keeps its pc
	pc_frozen: assert property (@(posedge clk) disable iff (reset_i)
		(finish_o || invalid_o) |=> $stable(pc_o))
	else $error("pc_o moved while halted");

endmodule

bind core_top core_props u_props (
	.clk       (clk),
	.reset_i   (reset_i),
	.pc_o      (pc_o),
	.dmem_we_o (dmem_we_o),
	.finish_o  (finish_o),
	.invalid_o (invalid_o)
);

`default_nettype wire

/* bench/core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module core_tb;
	import core_pkg::*;

	// 32 executed instructions, 10 reset and 8 settle cycles per test
	localparam int CYCLE_LIMIT = 32 * 4 + 6 * (10 + 8) + 100;
	localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

	logic clk = 1'b0;
	logic reset_i = 1'b1;
	logic [XLEN-1:0] imem_rdata_i;
	logic [XLEN-1:0] dmem_rdata_i;
	logic [XLEN-1:0] imem_addr_o, dmem_addr_o, dmem_wdata_o, pc_o;
	logic dmem_we_o, finish_o, invalid_o;

	logic [31:0] imem [64];
	logic [31:0] dmem [64];
	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];
	string test_name;
	int errors = 0;
	int test_errors;
	int tests_run = 0;
	int tests_failed = 0;
	int cycles = 0;
	logic [19:0] ua;
	logic [11:0] ia, ib;
	logic [31:0] w1, w2;

	core_top u_dut (
		.clk          (clk),
		.reset_i      (reset_i),
		.imem_rdata_i (imem_rdata_i),
		.dmem_rdata_i (dmem_rdata_i),
		.imem_addr_o  (imem_addr_o),
		.dmem_addr_o  (dmem_addr_o),
		.dmem_wdata_o (dmem_wdata_o),
		.dmem_we_o    (dmem_we_o),
		.pc_o         (pc_o),
		.finish_o     (finish_o),
		.invalid_o    (invalid_o)
	);

	always #2 clk = ~clk;

	assign imem_rdata_i = imem[imem_addr_o[7:2]];
	assign dmem_rdata_i = dmem[dmem_addr_o[7:2]];

	always @(posedge clk) begin
		if (dmem_we_o) begin
			dmem[dmem_addr_o[7:2]] <= dmem_wdata_o;
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: the core did not halt within %0d cycles", CYCLE_LIMIT);
			$display("Test failures found");
			$finish;
		end
	end

	function automatic logic [31:0] sext12(input logic [11:0] v);
		return {{20{v[11]}}, v};
	endfunction

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input int rd, rs1, rs2);
		return {f7, 5'(rs2), 5'(rs1), 3'b000, 5'(rd), 7'b0110011};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input int rd, rs1,
			input logic [2:0] f3, input logic [6:0] opc);
		return {imm, 5'(rs1), f3, 5'(rd), opc};
	endfunction

	function automatic logic [31:0] enc_sw(input logic [11:0] imm, input int rs1, rs2);
		return {imm[11:5], 5'(rs2), 5'(rs1), 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] imm, input int rs1, rs2,
			input logic [2:0] f3);
		return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] enc_jal(input logic [20:0] imm, input int rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), 7'b1101111};
	endfunction

	task automatic report_mismatch(input string what, input logic [31:0] exp, act);
		$display("ERR %s %s expected %h actual %h", test_name, what, exp, act);
		test_errors++;
	endtask

	task automatic report_problem(input string what);
		$display("%s: %s", test_name, what);
		test_errors++;
	endtask

	// store monitor, sampled mid-cycle where the strobe is stable
	always @(negedge clk) begin
		if (!reset_i && dmem_we_o) begin
			if (exp_addr.size() == 0) begin
				report_problem("a store happened that the program should not make");
			end else begin
				assert (dmem_addr_o == exp_addr[0])
				else report_mismatch("store address", exp_addr[0], dmem_addr_o);
				assert (dmem_wdata_o == exp_data[0])
				else report_mismatch("store data", exp_data[0], dmem_wdata_o);
				void'(exp_addr.pop_front());
				void'(exp_data.pop_front());
			end
		end
	end

	task automatic start_test(input string name);
		test_name = name;
		test_errors = 0;
		exp_addr.delete();
		exp_data.delete();
		for (int i = 0; i < 64; i++) begin
			imem[i] = {6'(i), 26'h3ff_ffff};
			dmem[i] = '0;
		end
	endtask

	task automatic expect_store(input logic [31:0] addr, data);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
	endtask

	task automatic apply_reset();
		@(negedge clk);
		reset_i = 1'b1;
		repeat (10) @(negedge clk);
		assert (pc_o == RESET_PC) else report_mismatch("pc in reset", RESET_PC, pc_o);
		assert (!dmem_we_o && !finish_o && !invalid_o)
		else report_problem("a strobe or halt output is high during reset");
		reset_i = 1'b0;
	endtask

	task automatic run_and_close(input logic expect_invalid, input logic [31:0] halt_pc);
		while (!(finish_o || invalid_o)) begin
			@(negedge clk);
		end
		repeat (8) @(negedge clk);
		assert (finish_o == !expect_invalid)
		else report_mismatch("finish", 32'(!expect_invalid), 32'(finish_o));
		assert (invalid_o == expect_invalid)
		else report_mismatch("invalid", 32'(expect_invalid), 32'(invalid_o));
		assert (pc_o == halt_pc) else report_mismatch("halt pc", halt_pc, pc_o);
		assert (exp_addr.size() == 0) else report_problem("expected stores never happened");
		tests_run++;
		if (test_errors != 0) begin
			tests_failed++;
		end
		errors += test_errors;
		$display("%s: %s (%0d errors)", test_name, test_errors == 0 ? "ok" : "FAILED",
			test_errors);
	endtask

	initial begin
		void'($urandom(32'h5035));

		start_test("reset_state");
		imem[0] = EBREAK_WORD;
		apply_reset();
		// first cycle out of reset, fetch has started but pc is untouched
		@(negedge clk);
		assert (pc_o == RESET_PC) else report_mismatch("pc after reset", RESET_PC, pc_o);
		assert (!dmem_we_o && !finish_o && !invalid_o)
		else report_problem("a strobe or halt output is high right after reset");
		run_and_close(1'b0, 32'h0);

		start_test("alu_store");
		ua = 20'($urandom);
		ia = 12'($urandom);
		ib = 12'($urandom);
		w1 = {ua, 12'b0} + sext12(ia);
		imem[0] = {ua, 5'd1, 7'b0110111};
		imem[1] = enc_i(ia, 1, 1, 3'b000, 7'b0010011);
		imem[2] = enc_i(ib, 2, 0, 3'b000, 7'b0010011);
		imem[3] = enc_r(7'b0000000, 3, 1, 2);
		imem[4] = enc_r(7'b0100000, 4, 1, 2);
		imem[5] = enc_sw(12'd0, 0, 1);
		imem[6] = enc_sw(12'd4, 0, 3);
		imem[7] = enc_sw(12'd8, 0, 4);
		imem[8] = EBREAK_WORD;
		expect_store(32'd0, w1);
		expect_store(32'd4, w1 + sext12(ib));
		expect_store(32'd8, w1 - sext12(ib));
		apply_reset();
		run_and_close(1'b0, 32'd32);

		start_test("load_store");
		ua = 20'($urandom);
		ia = 12'($urandom);
		w2 = {ua, 12'b0} + sext12(ia);
		imem[0] = {ua, 5'd1, 7'b0110111};
		imem[1] = enc_i(ia, 1, 1, 3'b000, 7'b0010011);
		imem[2] = enc_sw(12'd16, 0, 1);
		imem[3] = enc_i(12'd16, 2, 0, 3'b010, 7'b0000011);
		imem[4] = enc_i(12'd1, 2, 2, 3'b000, 7'b0010011);
		imem[5] = enc_sw(12'd20, 0, 2);
		imem[6] = EBREAK_WORD;
		expect_store(32'd16, w2);
		expect_store(32'd20, w2 + 32'd1);
		apply_reset();
		run_and_close(1'b0, 32'd24);

		start_test("branch_jump");
		imem[0] = enc_i(12'd5, 1, 0, 3'b000, 7'b0010011);
		imem[1] = enc_i(12'd5, 2, 0, 3'b000, 7'b0010011);
		imem[2] = enc_b(13'd8, 1, 2, 3'b000);
		imem[3] = enc_sw(12'd0, 0, 1);
		imem[4] = enc_b(13'd8, 1, 2, 3'b001);
		imem[5] = enc_sw(12'd4, 0, 2);
		imem[6] = enc_jal(21'd8, 3);
		imem[7] = enc_sw(12'd8, 0, 1);
		imem[8] = enc_sw(12'd12, 0, 3);
		imem[9] = enc_b(13'd8, 1, 0, 3'b001);
		imem[10] = enc_sw(12'd16, 0, 1);
		imem[11] = EBREAK_WORD;
		expect_store(32'd4, 32'd5);
		// link of the jal at address 24
		expect_store(32'd12, 32'd28);
		apply_reset();
		run_and_close(1'b0, 32'd44);

		start_test("halt_x0");
		imem[0] = enc_i(12'd123, 0, 0, 3'b000, 7'b0010011);
		imem[1] = enc_sw(12'd8, 0, 0);
		imem[2] = EBREAK_WORD;
		expect_store(32'd8, 32'd0);
		apply_reset();
		run_and_close(1'b0, 32'd8);

		start_test("invalid_op");
		imem[0] = enc_i(12'd7, 1, 0, 3'b000, 7'b0010011);
		imem[1] = enc_sw(12'd0, 0, 1);
		imem[2] = 32'hffff_ffff;
		imem[3] = enc_sw(12'd4, 0, 1);
		expect_store(32'd0, 32'd7);
		apply_reset();
		run_and_close(1'b1, 32'd8);

		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
hw/core_pkg.sv
hw/fetch_unit.sv
hw/decoder.sv
hw/register_file.sv
hw/execute_unit.sv
hw/lsu_wb.sv
hw/core_top.sv
bench/core_props.sv
bench/core_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f verilog.f --top-module core_tb -o core_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/core_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Test failures found" "$LOG"; then
	exit 1
fi

if ! grep -q "All tests passed!" "$LOG"; then
	echo "simulation ended without a result"
	exit 1
fi

exit 0
